//--- Bender.yml
package:
  name: readout_rx

sources:
  - include_dirs:
      - hw
    files:
      - hw/readout_dsp_pkg.sv
      - hw/readout_decision_pkg.sv
      - hw/iq_demodulator.sv
      - hw/iq_moving_average.sv
      - hw/state_discriminator.sv
      - hw/readout_rx.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/readout_rx_sva.sv
      - verification/readout_rx_tb.sv

//--- hw/iq_demodulator.sv
module iq_demodulator (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  logic                       i_ftw_wr_en,
    input  readout_dsp_pkg::ftw_t      i_ftw,
    input  logic                       i_sin_wr_en,
    input  logic                       i_cos_wr_en,
    input  readout_dsp_pkg::phase_t    i_lut_wr_addr,
    input  readout_dsp_pkg::sample_t   i_lut_wr_data,
    input  logic                       i_valid_inst,
    input  readout_dsp_pkg::sample_t   i_i,
    input  readout_dsp_pkg::sample_t   i_q,
    output logic                       o_mix_valid,
    output readout_dsp_pkg::sample_t   o_mix_i,
    output readout_dsp_pkg::sample_t   o_mix_q
);
    import readout_dsp_pkg::*;

    localparam int IQ_W       = $bits(sample_t);
    localparam int FTW_W      = $bits(ftw_t);
    localparam int PHASE_W    = $bits(phase_t);
    localparam int LUT_DEPTH  = 1 << PHASE_W;
    localparam int FULL_W     = 2 * IQ_W + 1;

    ftw_t    ftw_q;
    ftw_t    phase_acc;
    phase_t  rd_phase;
    logic    valid_d1;
    logic    valid_d2;
    sample_t i_d1;
    sample_t q_d1;
    sample_t i_d2;
    sample_t q_d2;
    sample_t sin_rd;
    sample_t cos_rd;
    sample_t sin_lut [LUT_DEPTH];
    sample_t cos_lut [LUT_DEPTH];

    logic signed [FULL_W-1:0] mix_i_full;
    logic signed [FULL_W-1:0] mix_q_full;

    // accumulator only advances on valid samples and holds across bursts
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ftw_q     <= '0;
            phase_acc <= '0;
            valid_d1  <= 1'b0;
            valid_d2  <= 1'b0;
            o_mix_valid <= 1'b0;
        end else begin
            if (i_ftw_wr_en) begin
                ftw_q <= i_ftw;
            end
            if (i_valid_inst) begin
                phase_acc <= phase_acc + ftw_q;
            end
            valid_d1    <= i_valid_inst;
            valid_d2    <= valid_d1;
            o_mix_valid <= valid_d2;
        end
    end

    // phase taken before the add
    always_ff @(posedge clk) begin
        rd_phase <= phase_acc[FTW_W-1 -: PHASE_W];
        i_d1     <= i_i;
        q_d1     <= i_q;
    end

    // tables with synchronous read
    always_ff @(posedge clk) begin
        if (i_sin_wr_en) begin
            sin_lut[i_lut_wr_addr] <= i_lut_wr_data;
        end
        if (i_cos_wr_en) begin
            cos_lut[i_lut_wr_addr] <= i_lut_wr_data;
        end
        sin_rd <= sin_lut[rd_phase];
        cos_rd <= cos_lut[rd_phase];
        // samples delayed to meet the table output
        i_d2   <= i_d1;
        q_d2   <= q_d1;
    end

    always_comb begin
        mix_i_full = i_d2 * cos_rd + q_d2 * sin_rd;
        mix_q_full = q_d2 * cos_rd - i_d2 * sin_rd;
    end

    // drop the Q1.15 fraction bits of the tables
    always_ff @(posedge clk) begin
        o_mix_i <= sample_t'(mix_i_full >>> (IQ_W - 1));
        o_mix_q <= sample_t'(mix_q_full >>> (IQ_W - 1));
    end

endmodule

//--- hw/iq_moving_average.sv
`include "readout_macros.svh"

module iq_moving_average (
    input  logic                       clk,
    input  logic                       i_arst_n,
    input  logic                       i_mix_valid,
    input  readout_dsp_pkg::sample_t   i_mix_i,
    input  readout_dsp_pkg::sample_t   i_mix_q,
    output logic                       o_avg_valid,
    output readout_dsp_pkg::sample_t   o_avg_i,
    output readout_dsp_pkg::sample_t   o_avg_q
);
    import readout_dsp_pkg::*;

    localparam int LOG2  = `READOUT_AVG_LOG2;
    localparam int DEPTH = 1 << LOG2;
    localparam int SUM_W = $bits(sample_t) + LOG2;

    sample_t            win_i [DEPTH];
    sample_t            win_q [DEPTH];
    logic [LOG2-1:0]    wr_ptr;
    logic [LOG2:0]      fill;
    logic               full;
    sample_t            old_i;
    sample_t            old_q;
    logic signed [SUM_W-1:0] sum_i;
    logic signed [SUM_W-1:0] sum_q;
    logic signed [SUM_W-1:0] sum_i_next;
    logic signed [SUM_W-1:0] sum_q_next;

    assign full = (fill == (LOG2 + 1)'(DEPTH));

    // oldest entry only leaves once the window is full
    always_comb begin
        old_i      = full ? win_i[wr_ptr] : '0;
        old_q      = full ? win_q[wr_ptr] : '0;
        sum_i_next = sum_i + i_mix_i - old_i;
        sum_q_next = sum_q + i_mix_q - old_q;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr      <= '0;
            fill        <= '0;
            sum_i       <= '0;
            sum_q       <= '0;
            o_avg_valid <= 1'b0;
        end else if (i_mix_valid) begin
            wr_ptr      <= wr_ptr + 1'b1;
            sum_i       <= sum_i_next;
            sum_q       <= sum_q_next;
            if (!full) begin
                fill <= fill + 1'b1;
            end
            // this sample makes eight or more
            o_avg_valid <= (fill >= (LOG2 + 1)'(DEPTH - 1));
        end else begin
            // idle cycle ends the burst
            wr_ptr      <= '0;
            fill        <= '0;
            sum_i       <= '0;
            sum_q       <= '0;
            o_avg_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_mix_valid) begin
            win_i[wr_ptr] <= i_mix_i;
            win_q[wr_ptr] <= i_mix_q;
        end
        o_avg_i <= sum_i_next[SUM_W-1:LOG2];
        o_avg_q <= sum_q_next[SUM_W-1:LOG2];
    end

endmodule

//--- hw/readout_decision_pkg.sv
package readout_decision_pkg;

    // coefficient register select
    typedef enum logic {
        COEFF_INTERCEPT = 1'b0,
        COEFF_SLOPE     = 1'b1
    } coeff_addr_e;

    // signed Q8.8 slope with the whole part in the upper byte
    typedef struct packed {
        logic signed [7:0] whole;
        logic [7:0]        frac;
    } slope_q8_8_t;

    // one coefficient word read as intercept or as slope
    typedef union packed {
        logic signed [15:0] intercept;
        slope_q8_8_t        slope;
    } coeff_word_u;

endpackage

//--- hw/readout_dsp_pkg.sv
`include "readout_macros.svh"

package readout_dsp_pkg;

    // one two's complement I or Q word
    typedef logic signed [`READOUT_IQ_W-1:0] sample_t;

    // sine and cosine table address
    typedef logic [`READOUT_PHASE_W-1:0] phase_t;

    // NCO frequency word as wide as the accumulator
    typedef logic [`READOUT_FTW_W-1:0] ftw_t;

    // signed burst sum
    typedef logic signed [`READOUT_ACC_W-1:0] acc_t;

endpackage

//--- hw/readout_macros.svh
`ifndef READOUT_MACROS_SVH
`define READOUT_MACROS_SVH

// sample width of the incoming I/Q words
`define READOUT_IQ_W 16

// frequency word and phase accumulator width
`define READOUT_FTW_W 22

// table address taken from the top bits of the accumulator
`define READOUT_PHASE_W 10

// moving average window depth is 2**READOUT_AVG_LOG2
`define READOUT_AVG_LOG2 3

// burst integration width
`define READOUT_ACC_W 32

`endif

//--- hw/readout_rx.sv
module readout_rx (
    input  logic                              clk,
    input  logic                              i_arst_n,
    input  logic                              i_ftw_wr_en,
    input  readout_dsp_pkg::ftw_t             i_ftw,
    input  logic                              i_sin_wr_en,
    input  logic                              i_cos_wr_en,
    input  readout_dsp_pkg::phase_t           i_lut_wr_addr,
    input  readout_dsp_pkg::sample_t          i_lut_wr_data,
    input  logic                              i_coeff_wr_en,
    input  readout_decision_pkg::coeff_addr_e i_coeff_wr_addr,
    input  readout_decision_pkg::coeff_word_u i_coeff_wr_data,
    input  logic                              i_valid_inst,
    input  readout_dsp_pkg::sample_t          i_i,
    input  readout_dsp_pkg::sample_t          i_q,
    output logic                              o_filter_valid,
    output readout_dsp_pkg::sample_t          o_i_filter,
    output readout_dsp_pkg::sample_t          o_q_filter,
    output logic                              o_meas_valid,
    output logic                              o_meas_result
);
    import readout_dsp_pkg::*;

    logic    mix_valid;
    sample_t mix_i;
    sample_t mix_q;

    iq_demodulator u_demod (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_ftw_wr_en   (i_ftw_wr_en),
        .i_ftw         (i_ftw),
        .i_sin_wr_en   (i_sin_wr_en),
        .i_cos_wr_en   (i_cos_wr_en),
        .i_lut_wr_addr (i_lut_wr_addr),
        .i_lut_wr_data (i_lut_wr_data),
        .i_valid_inst  (i_valid_inst),
        .i_i           (i_i),
        .i_q           (i_q),
        .o_mix_valid   (mix_valid),
        .o_mix_i       (mix_i),
        .o_mix_q       (mix_q)
    );

    // filter outputs go both off-chip and into the discriminator
    iq_moving_average u_avg (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_mix_valid (mix_valid),
        .i_mix_i     (mix_i),
        .i_mix_q     (mix_q),
        .o_avg_valid (o_filter_valid),
        .o_avg_i     (o_i_filter),
        .o_avg_q     (o_q_filter)
    );

    state_discriminator u_disc (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_coeff_wr_en   (i_coeff_wr_en),
        .i_coeff_wr_addr (i_coeff_wr_addr),
        .i_coeff_wr_data (i_coeff_wr_data),
        .i_avg_valid     (o_filter_valid),
        .i_avg_i         (o_i_filter),
        .i_avg_q         (o_q_filter),
        .o_meas_valid    (o_meas_valid),
        .o_meas_result   (o_meas_result)
    );

endmodule

//--- hw/state_discriminator.sv
module state_discriminator (
    input  logic                              clk,
    input  logic                              i_arst_n,
    input  logic                              i_coeff_wr_en,
    input  readout_decision_pkg::coeff_addr_e i_coeff_wr_addr,
    input  readout_decision_pkg::coeff_word_u i_coeff_wr_data,
    input  logic                              i_avg_valid,
    input  readout_dsp_pkg::sample_t          i_avg_i,
    input  readout_dsp_pkg::sample_t          i_avg_q,
    output logic                              o_meas_valid,
    output logic                              o_meas_result
);
    import readout_dsp_pkg::*;
    import readout_decision_pkg::*;

    localparam int PROD_W = $bits(acc_t) + $bits(coeff_word_u);

    coeff_word_u intercept_r;
    coeff_word_u slope_r;
    logic        avg_valid_d;
    logic        burst_end;
    acc_t        sum_i;
    acc_t        sum_q;

    logic signed [PROD_W-1:0] lhs;
    logic signed [PROD_W-1:0] whole_term;
    logic signed [PROD_W-1:0] frac_term;
    logic signed [PROD_W-1:0] icpt_term;
    logic                     above_line;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            intercept_r <= '0;
            slope_r     <= '0;
        end else if (i_coeff_wr_en) begin
            unique case (i_coeff_wr_addr)
                COEFF_SLOPE:     slope_r     <= i_coeff_wr_data;
                COEFF_INTERCEPT: intercept_r <= i_coeff_wr_data;
            endcase
        end
    end

    assign burst_end = avg_valid_d && !i_avg_valid;

    // first valid of a burst restarts the sums
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            avg_valid_d  <= 1'b0;
            sum_i        <= '0;
            sum_q        <= '0;
            o_meas_valid <= 1'b0;
        end else begin
            avg_valid_d  <= i_avg_valid;
            o_meas_valid <= burst_end;
            if (i_avg_valid) begin
                if (!avg_valid_d) begin
                    sum_i <= acc_t'(i_avg_i);
                    sum_q <= acc_t'(i_avg_q);
                end else begin
                    sum_i <= sum_i + acc_t'(i_avg_i);
                    sum_q <= sum_q + acc_t'(i_avg_q);
                end
            end
        end
    end

    // line rule with every term scaled by 256
    always_comb begin
        lhs        = PROD_W'(sum_q) <<< 8;
        whole_term = (PROD_W'(sum_i) * PROD_W'($signed(slope_r.slope.whole))) <<< 8;
        frac_term  = PROD_W'(sum_i) * PROD_W'($signed({1'b0, slope_r.slope.frac}));
        icpt_term  = PROD_W'(intercept_r.intercept) <<< 8;
        above_line = lhs > (whole_term + frac_term + icpt_term);
    end

    always_ff @(posedge clk) begin
        if (burst_end) begin
            o_meas_result <= above_line;
        end
    end

endmodule

//--- sources.f
+incdir+hw
hw/readout_dsp_pkg.sv
hw/readout_decision_pkg.sv
hw/iq_demodulator.sv
hw/iq_moving_average.sv
hw/state_discriminator.sv
hw/readout_rx.sv
verification/readout_rx_sva.sv
verification/readout_rx_tb.sv

//--- verification/readout_rx_sva.sv
module readout_rx_sva (
    input logic clk,
    input logic i_arst_n,
    input logic i_filter_valid,
    input logic i_meas_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // measurement strobe lasts one cycle
    meas_pulse_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_meas_valid |=> !i_meas_valid)
        else $error("o_meas_valid stayed high for more than one cycle");

    // strobe follows the falling edge of the filter valid
    meas_after_fall_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_meas_valid |-> $past(i_filter_valid, 2) && !$past(i_filter_valid))
        else $error("o_meas_valid without a preceding end of filter outputs");

    reset_quiet_a: assert property (@(posedge clk)
        !i_arst_n |-> !i_filter_valid && !i_meas_valid)
        else $error("a valid output was high during reset");

endmodule

bind readout_rx readout_rx_sva i_sva (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_filter_valid (o_filter_valid),
    .i_meas_valid   (o_meas_valid)
);

//--- verification/readout_rx_tb.sv
`include "readout_macros.svh"

module readout_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import readout_dsp_pkg::*;
    import readout_decision_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int LUT_DEPTH      = 1 << `READOUT_PHASE_W;

    logic        clk = 1'b0;
    logic        i_arst_n;
    logic        i_ftw_wr_en;
    ftw_t        i_ftw;
    logic        i_sin_wr_en;
    logic        i_cos_wr_en;
    phase_t      i_lut_wr_addr;
    sample_t     i_lut_wr_data;
    logic        i_coeff_wr_en;
    coeff_addr_e i_coeff_wr_addr;
    coeff_word_u i_coeff_wr_data;
    logic        i_valid_inst;
    sample_t     i_i;
    sample_t     i_q;
    logic        o_filter_valid;
    sample_t     o_i_filter;
    sample_t     o_q_filter;
    logic        o_meas_valid;
    logic        o_meas_result;

    integer      seed = 51;

    // reference copies of the tables, NCO and coefficients
    sample_t     ref_sin [LUT_DEPTH];
    sample_t     ref_cos [LUT_DEPTH];
    ftw_t        ref_ftw;
    ftw_t        ref_acc;
    int          ref_whole;
    int          ref_frac;
    int          ref_icpt;

    sample_t     exp_fi [$];
    sample_t     exp_fq [$];
    bit          exp_meas [$];

    readout_rx i_dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // drop the Q1.15 fraction bits of a product sum
    function automatic sample_t scale_product(input longint sum);
        longint shifted;
        shifted = sum >>> 15;
        return sample_t'(shifted);
    endfunction

    function automatic bit decide_ref(input longint sum_i, input longint sum_q);
        longint rhs;
        rhs = ref_whole * sum_i * 256 + ref_frac * sum_i + ref_icpt * 256;
        return (sum_q * 256) > rhs;
    endfunction

    task automatic write_lut(input bit to_cos, input int addr, input sample_t data);
        @(posedge clk);
        i_sin_wr_en   <= !to_cos;
        i_cos_wr_en   <= to_cos;
        i_lut_wr_addr <= phase_t'(addr);
        i_lut_wr_data <= data;
        if (to_cos) begin
            ref_cos[addr] = data;
        end else begin
            ref_sin[addr] = data;
        end
    endtask

    task automatic release_writes();
        @(posedge clk);
        i_sin_wr_en   <= 1'b0;
        i_cos_wr_en   <= 1'b0;
        i_ftw_wr_en   <= 1'b0;
        i_coeff_wr_en <= 1'b0;
    endtask

    task automatic write_ftw(input ftw_t value);
        @(posedge clk);
        i_ftw_wr_en <= 1'b1;
        i_ftw       <= value;
        ref_ftw = value;
        release_writes();
    endtask

    task automatic set_coefficients(input int whole, input int frac, input int icpt);
        coeff_word_u word;
        word.slope.whole = whole[7:0];
        word.slope.frac  = frac[7:0];
        @(posedge clk);
        i_coeff_wr_en   <= 1'b1;
        i_coeff_wr_addr <= COEFF_SLOPE;
        i_coeff_wr_data <= word;
        word.intercept = icpt[15:0];
        @(posedge clk);
        i_coeff_wr_addr <= COEFF_INTERCEPT;
        i_coeff_wr_data <= word;
        release_writes();
        ref_whole = $signed(whole[7:0]);
        ref_frac  = frac[7:0];
        ref_icpt  = $signed(icpt[15:0]);
    endtask

    // expected outputs are queued before the samples go in
    task automatic drive_burst(input int len);
        sample_t si;
        sample_t sq;
        phase_t  ph;
        longint  li;
        longint  lq;
        longint  lc;
        longint  ls;
        longint  hist_i [$];
        longint  hist_q [$];
        longint  wsum_i;
        longint  wsum_q;
        longint  tot_i;
        longint  tot_q;
        sample_t fi;
        sample_t fq;
        int      k;
        int      j;
        tot_i = 0;
        tot_q = 0;
        for (k = 0; k < len; k++) begin
            si = sample_t'($random(seed));
            sq = sample_t'($random(seed));
            ph = ref_acc[`READOUT_FTW_W-1 -: `READOUT_PHASE_W];
            li = si;
            lq = sq;
            lc = ref_cos[ph];
            ls = ref_sin[ph];
            hist_i.push_back(scale_product(li * lc + lq * ls));
            hist_q.push_back(scale_product(lq * lc - li * ls));
            ref_acc = ref_acc + ref_ftw;
            if (k >= 7) begin
                wsum_i = 0;
                wsum_q = 0;
                for (j = k - 7; j <= k; j++) begin
                    wsum_i += hist_i[j];
                    wsum_q += hist_q[j];
                end
                fi = sample_t'(wsum_i >>> 3);
                fq = sample_t'(wsum_q >>> 3);
                exp_fi.push_back(fi);
                exp_fq.push_back(fq);
                tot_i += fi;
                tot_q += fq;
            end
            @(posedge clk);
            i_valid_inst <= 1'b1;
            i_i          <= si;
            i_q          <= sq;
        end
        @(posedge clk);
        i_valid_inst <= 1'b0;
        if (len >= 8) begin
            exp_meas.push_back(decide_ref(tot_i, tot_q));
        end
    endtask

    task automatic wait_drained(output bit drained);
        int n;
        n = 0;
        while ((exp_fi.size() != 0 || exp_meas.size() != 0) && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        drained = (exp_fi.size() == 0 && exp_meas.size() == 0);
    endtask

    initial begin : compare
        sample_t want_i;
        sample_t want_q;
        bit      want_r;
        forever begin
            @(negedge clk);
            if (o_filter_valid !== 1'b0) begin
                assert (exp_fi.size() > 0)
                    else report_failure("a filter output appeared when none was expected");
                want_i = exp_fi.pop_front();
                want_q = exp_fq.pop_front();
                assert (o_i_filter == want_i)
                    else report_failure($sformatf("error: o_i_filter is %h, expected %h",
                                                  o_i_filter, want_i));
                assert (o_q_filter == want_q)
                    else report_failure($sformatf("error: o_q_filter is %h, expected %h",
                                                  o_q_filter, want_q));
            end
            if (o_meas_valid !== 1'b0) begin
                assert (exp_meas.size() > 0)
                    else report_failure("a measurement result appeared when none was expected");
                want_r = exp_meas.pop_front();
                assert (o_meas_result == want_r)
                    else report_failure($sformatf("error: o_meas_result is %h, expected %h",
                                                  o_meas_result, want_r));
            end
        end
    end

    initial begin : stimulus
        bit ok;
        int n;
        i_arst_n        = 1'b1;
        i_ftw_wr_en     = 1'b0;
        i_ftw           = '0;
        i_sin_wr_en     = 1'b0;
        i_cos_wr_en     = 1'b0;
        i_lut_wr_addr   = '0;
        i_lut_wr_data   = '0;
        i_coeff_wr_en   = 1'b0;
        i_coeff_wr_addr = COEFF_INTERCEPT;
        i_coeff_wr_data = '0;
        i_valid_inst    = 1'b0;
        i_i             = '0;
        i_q             = '0;
        ref_acc         = '0;
        ref_ftw         = '0;
        @(posedge clk);
        i_arst_n <= 1'b0;
        repeat (4) @(posedge clk);
        i_arst_n <= 1'b1;
        // outputs must stay quiet while nothing is driven
        repeat (10) @(posedge clk);

        for (n = 0; n < LUT_DEPTH; n++) begin
            write_lut(1'b0, n, sample_t'($random(seed)));
            write_lut(1'b1, n, sample_t'($random(seed)));
        end
        release_writes();
        write_ftw(ftw_t'($random(seed)));
        set_coefficients($random(seed) % 128, ($random(seed) & 8'hff) | 1,
                         -1 - ($random(seed) & 16'h3fff));
        for (n = 0; n < 4; n++) begin
            drive_burst(8 + ($unsigned($random(seed)) % 33));
            repeat (3) @(posedge clk);
        end
        drive_burst(5);
        wait_drained(ok);
        if (!ok) begin
            report_failure("timed out waiting for the first set of bursts");
        end

        // new NCO step, some new table words, a negative slope
        write_ftw(ftw_t'($random(seed)));
        for (n = 0; n < 32; n++) begin
            write_lut(n[0], $unsigned($random(seed)) % LUT_DEPTH, sample_t'($random(seed)));
        end
        release_writes();
        set_coefficients(-1 - ($random(seed) & 8'h3f), ($random(seed) & 8'hff) | 8'h10,
                         -1 - ($random(seed) & 16'h0fff));
        drive_burst(8 + ($unsigned($random(seed)) % 33));
        drive_burst(6);
        drive_burst(8);
        drive_burst(8 + ($unsigned($random(seed)) % 33));
        drive_burst(8 + ($unsigned($random(seed)) % 33));

        wait_drained(ok);
        if (ok) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure("timed out waiting for the back-to-back bursts");
        end
    end

endmodule
